//--- rtl/exe_consts.svh
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// one-hot op vector
`define EXE_ALU_OP_W    16
`define EXE_OP_ADD      0
`define EXE_OP_SUB      1
`define EXE_OP_SLT      2
`define EXE_OP_SLTU     3
`define EXE_OP_AND      4
`define EXE_OP_NOR      5
`define EXE_OP_OR       6
`define EXE_OP_XOR      7
`define EXE_OP_SLL      8
`define EXE_OP_SRL      9
`define EXE_OP_SRA      10
`define EXE_OP_LUI      11
`define EXE_OP_DIVW     12
`define EXE_OP_MODW     13
`define EXE_OP_DIVWU    14
`define EXE_OP_MODWU    15

// 32 iterations plus the sign fix-up
`define EXE_DIV_CYCLES  33

`define EXE_LOAD_OP_W   5
`define EXE_STORE_OP_W  3
`define EXE_ST_B        0
`define EXE_ST_H        1
`define EXE_ST_W        2
`define EXE_BRANCH_OP_W 9
`define EXE_REG_W       5

`endif

//--- rtl/exe_pkg.sv
`include "exe_consts.svh"

package exe_pkg;

    // decoded instruction from decode
    typedef struct packed {
        logic [`EXE_ALU_OP_W-1:0]    alu_op;
        logic                        src1_is_pc;
        logic                        src2_is_imm;
        logic                        src2_is_4;
        logic                        mem_to_reg;
        logic                        reg_we;
        logic                        mem_we;
        logic [`EXE_LOAD_OP_W-1:0]   load_op;
        logic [`EXE_STORE_OP_W-1:0]  store_op;
        logic [`EXE_BRANCH_OP_W-1:0] branch_op;
        logic [`EXE_REG_W-1:0]       dest;
        logic [31:0]                 imm;
        logic [31:0]                 rdata1;
        logic [31:0]                 rdata2;
        logic [31:0]                 pc;
    } ds_to_es_t;

    // forwarding selects from the hazard unit
    typedef struct packed {
        logic src1_from_ms;
        logic src1_from_ws;
        logic src2_from_ms;
        logic src2_from_ws;
        logic st_from_ws;
    } fw_sel_t;

    typedef struct packed {
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] st_data;
        ds_to_es_t   inst;
    } exe_ops_t;

    typedef struct packed {
        logic [31:0]                 br_target;
        logic [`EXE_BRANCH_OP_W-1:0] branch_op;
        logic                        carry;
        logic                        sign;
        logic                        overflow;
        logic                        zero;
        logic [`EXE_LOAD_OP_W-1:0]   load_op;
        logic                        mem_to_reg;
        logic                        reg_we;
        logic [`EXE_REG_W-1:0]       dest;
        logic [31:0]                 result;
        logic [31:0]                 pc;
    } es_to_ms_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  wen;
        logic [31:0] addr;
        logic [31:0] wdata;
    } sram_req_t;

    // one word seen as lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
        logic [31:0]      word;
    } store_word_u;

endpackage

//--- rtl/exe_issue.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_issue (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_valid,
    input  exe_pkg::ds_to_es_t ds_bus,
    input  exe_pkg::fw_sel_t   fw_sel,
    input  logic [31:0]        ms_fwd,
    input  logic [31:0]        ws_fwd,
    input  logic               es_allowin,
    output logic               item_valid,
    output exe_pkg::exe_ops_t  ops,
    output logic               div_start
);

    exe_pkg::ds_to_es_t bus_r;
    logic               is_div;
    logic               start_sent;

    always_ff @(posedge clk) begin
        if (reset) begin
            item_valid <= 1'b0;
        end else if (es_allowin) begin
            item_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            bus_r <= ds_bus;
        end
    end

    assign is_div    = |bus_r.alu_op[`EXE_OP_MODWU:`EXE_OP_DIVW];
    assign div_start = item_valid && is_div && !start_sent;

    // one start per held item
    always_ff @(posedge clk) begin
        if (reset || es_allowin) begin
            start_sent <= 1'b0;
        end else if (div_start) begin
            start_sent <= 1'b1;
        end
    end

    always_comb begin
        ops.inst = bus_r;
        if (bus_r.src1_is_pc) ops.src1 = bus_r.pc;
        else if (fw_sel.src1_from_ms) ops.src1 = ms_fwd;
        else if (fw_sel.src1_from_ws) ops.src1 = ws_fwd;
        else ops.src1 = bus_r.rdata1;

        if (bus_r.src2_is_imm) ops.src2 = bus_r.imm;
        else if (bus_r.src2_is_4) ops.src2 = 32'd4;
        else if (fw_sel.src2_from_ms) ops.src2 = ms_fwd;
        else if (fw_sel.src2_from_ws) ops.src2 = ws_fwd;
        else ops.src2 = bus_r.rdata2;

        ops.st_data = fw_sel.st_from_ws ? ws_fwd : bus_r.rdata2;
    end

    assert property (@(posedge clk) disable iff (reset) div_start |-> item_valid);
    // divider needs far more than one cycle
    assert property (@(posedge clk) disable iff (reset) div_start |=> !div_start);

endmodule

//--- rtl/exe_alu.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_alu (
    input  exe_pkg::exe_ops_t ops,
    output logic [31:0]       result,
    output logic              carry,
    output logic              sign,
    output logic              overflow,
    output logic              zero
);

    logic [`EXE_ALU_OP_W-1:0] op;
    logic [31:0]              a;
    logic [31:0]              b;
    logic [31:0]              b_adj;
    logic                     use_sub;
    logic [32:0]              sum;
    logic [4:0]               shamt;
    logic [31:0]              sll_r;
    logic [31:0]              srl_r;
    logic [31:0]              sra_r;
    logic [31:0]              lui_r;
    exe_pkg::store_word_u     imm_w;

    assign op    = ops.inst.alu_op;
    assign a     = ops.src1;
    assign b     = ops.src2;
    assign shamt = b[4:0];

    // the shared adder subtracts for sub and the compares
    assign use_sub = op[`EXE_OP_SUB] | op[`EXE_OP_SLT] | op[`EXE_OP_SLTU];
    assign b_adj   = use_sub ? ~b : b;
    assign sum     = {1'b0, a} + {1'b0, b_adj} + {32'b0, use_sub};

    assign carry    = sum[32];
    assign sign     = sum[31];
    assign overflow = (a[31] == b_adj[31]) && (sum[31] != a[31]);
    assign zero     = (sum[31:0] == 32'b0);

    assign sll_r = a << shamt;
    assign srl_r = a >> shamt;
    assign sra_r = $signed(a) >>> shamt;

    // low 20 bits of the immediate moved up by 12
    assign imm_w.word = b;
    assign lui_r      = {imm_w.bytes[2][3:0], imm_w.bytes[1], imm_w.bytes[0], 12'b0};

    assign result = ({32{op[`EXE_OP_ADD] | op[`EXE_OP_SUB]}} & sum[31:0])
                  | ({32{op[`EXE_OP_SLT]}}  & {31'b0, sign ^ overflow})
                  | ({32{op[`EXE_OP_SLTU]}} & {31'b0, ~carry})
                  | ({32{op[`EXE_OP_AND]}}  & (a & b))
                  | ({32{op[`EXE_OP_NOR]}}  & ~(a | b))
                  | ({32{op[`EXE_OP_OR]}}   & (a | b))
                  | ({32{op[`EXE_OP_XOR]}}  & (a ^ b))
                  | ({32{op[`EXE_OP_SLL]}}  & sll_r)
                  | ({32{op[`EXE_OP_SRL]}}  & srl_r)
                  | ({32{op[`EXE_OP_SRA]}}  & sra_r)
                  | ({32{op[`EXE_OP_LUI]}}  & lui_r);

endmodule

//--- rtl/exe_divider.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_divider (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        is_signed,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic [31:0] remainder,
    output logic        busy,
    output logic        done
);

    logic [5:0]  count;
    logic        last;
    logic [31:0] rem_mag;
    logic [31:0] quo_mag;
    logic [31:0] div_mag;
    logic        neg_q;
    logic        neg_r;
    logic        div_zero;
    logic [33:0] trial;

    assign last  = (count == 6'(`EXE_DIV_CYCLES - 1));
    assign done  = busy && last;
    assign trial = {1'b0, rem_mag, quo_mag[31]} - {2'b00, div_mag};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            busy  <= !last;
            count <= count + 6'd1;
        end
    end

    // quotient bits shift in behind the dividend
    always_ff @(posedge clk) begin
        if (start) begin
            rem_mag  <= '0;
            quo_mag  <= (is_signed && dividend[31]) ? -dividend : dividend;
            div_mag  <= (is_signed && divisor[31]) ? -divisor : divisor;
            neg_q    <= is_signed && (dividend[31] ^ divisor[31]);
            neg_r    <= is_signed && dividend[31];
            div_zero <= (divisor == 32'b0);
        end else if (busy && !last) begin
            if (!trial[33]) begin
                rem_mag <= trial[31:0];
                quo_mag <= {quo_mag[30:0], 1'b1};
            end else begin
                rem_mag <= {rem_mag[30:0], quo_mag[31]};
                quo_mag <= {quo_mag[30:0], 1'b0};
            end
        end
    end

    // sign fix-up is valid in the done cycle and held after
    assign quotient  = div_zero ? '1 : (neg_q ? -quo_mag : quo_mag);
    assign remainder = neg_r ? -rem_mag : rem_mag;

    assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

//--- rtl/exe_retire.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_retire (
    input  logic                clk,
    input  logic                reset,
    input  logic                item_valid,
    input  exe_pkg::exe_ops_t   ops,
    input  logic [31:0]         alu_result,
    input  logic                carry,
    input  logic                sign,
    input  logic                overflow,
    input  logic                zero,
    input  logic [31:0]         div_q,
    input  logic [31:0]         div_r,
    input  logic                div_done,
    input  logic                ms_allowin,
    output logic                es_allowin,
    output logic                es_to_ms_valid,
    output exe_pkg::es_to_ms_t  es_bus,
    output exe_pkg::sram_req_t  sram
);

    logic                            is_div;
    logic                            done_seen;
    logic                            ready_go;
    logic [3:0]                      wen;
    logic [`EXE_STORE_OP_W-1:0]      st_op;
    exe_pkg::store_word_u            st_w;
    exe_pkg::store_word_u            lane_w;

    assign is_div = |ops.inst.alu_op[`EXE_OP_MODWU:`EXE_OP_DIVW];

    // keep the done pulse until the item leaves
    always_ff @(posedge clk) begin
        if (reset || es_allowin) begin
            done_seen <= 1'b0;
        end else if (div_done) begin
            done_seen <= 1'b1;
        end
    end

    assign ready_go       = !is_div || done_seen || div_done;
    assign es_allowin     = !item_valid || (ready_go && ms_allowin);
    assign es_to_ms_valid = item_valid && ready_go;

    always_comb begin
        es_bus.branch_op  = ops.inst.branch_op;
        es_bus.carry      = carry;
        es_bus.sign       = sign;
        es_bus.overflow   = overflow;
        es_bus.zero       = zero;
        es_bus.load_op    = ops.inst.load_op;
        es_bus.mem_to_reg = ops.inst.mem_to_reg;
        es_bus.reg_we     = ops.inst.reg_we;
        es_bus.dest       = ops.inst.dest;
        es_bus.pc         = ops.inst.pc;
        if (ops.inst.alu_op[`EXE_OP_DIVW] || ops.inst.alu_op[`EXE_OP_DIVWU]) es_bus.result = div_q;
        else if (is_div) es_bus.result = div_r;
        else es_bus.result = alu_result;

        // pc-relative first, jirl last
        if (|ops.inst.branch_op[7:0]) es_bus.br_target = ops.inst.pc + ops.inst.imm;
        else if (ops.inst.branch_op[8]) es_bus.br_target = ops.inst.rdata1 + ops.inst.imm;
        else es_bus.br_target = 32'b0;
    end

    assign st_op = ops.inst.store_op;

    always_comb begin
        st_w.word = ops.st_data;
        if (st_op[`EXE_ST_B]) begin
            wen          = 4'b0001 << alu_result[1:0];
            lane_w.bytes = {4{st_w.bytes[0]}};
        end else if (st_op[`EXE_ST_H]) begin
            wen           = alu_result[1] ? 4'b1100 : 4'b0011;
            lane_w.halves = {2{st_w.halves[0]}};
        end else begin
            wen         = st_op[`EXE_ST_W] ? 4'b1111 : 4'b0000;
            lane_w.word = st_w.word;
        end
    end

    assign sram.en    = 1'b1;
    assign sram.wen   = (item_valid && ops.inst.mem_we) ? wen : 4'b0000;
    assign sram.addr  = alu_result;
    assign sram.wdata = lane_w.word;

    assert property (@(posedge clk) disable iff (reset) es_to_ms_valid |-> item_valid);
    // an offered item is not withdrawn while memory stalls
    assert property (@(posedge clk) disable iff (reset)
        (es_to_ms_valid && !ms_allowin) |=> es_to_ms_valid);

endmodule

//--- rtl/exe_stage.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_valid,
    input  exe_pkg::ds_to_es_t ds_bus,
    input  exe_pkg::fw_sel_t   fw_sel,
    input  logic [31:0]        ms_fwd,
    input  logic [31:0]        ws_fwd,
    input  logic               ms_allowin,
    output logic               es_allowin,
    output logic               es_to_ms_valid,
    output exe_pkg::es_to_ms_t es_bus,
    output exe_pkg::sram_req_t sram
);

    logic              item_valid;
    exe_pkg::exe_ops_t ops;
    logic              div_start;
    logic              div_signed;
    logic              div_busy;
    logic              div_done;
    logic [31:0]       div_q;
    logic [31:0]       div_r;
    logic [31:0]       alu_result;
    logic              carry;
    logic              sign;
    logic              overflow;
    logic              zero;

    assign div_signed = ops.inst.alu_op[`EXE_OP_DIVW] | ops.inst.alu_op[`EXE_OP_MODW];

    exe_issue u_issue (
        .clk        (clk),
        .reset      (reset),
        .ds_valid   (ds_valid),
        .ds_bus     (ds_bus),
        .fw_sel     (fw_sel),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .es_allowin (es_allowin),
        .item_valid (item_valid),
        .ops        (ops),
        .div_start  (div_start)
    );

    exe_alu u_alu (
        .ops      (ops),
        .result   (alu_result),
        .carry    (carry),
        .sign     (sign),
        .overflow (overflow),
        .zero     (zero)
    );

    // src1 is the dividend, src2 the divisor
    exe_divider u_div (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (ops.src1),
        .divisor   (ops.src2),
        .quotient  (div_q),
        .remainder (div_r),
        .busy      (div_busy),
        .done      (div_done)
    );

    exe_retire u_retire (
        .clk            (clk),
        .reset          (reset),
        .item_valid     (item_valid),
        .ops            (ops),
        .alu_result     (alu_result),
        .carry          (carry),
        .sign           (sign),
        .overflow       (overflow),
        .zero           (zero),
        .div_q          (div_q),
        .div_r          (div_r),
        .div_done       (div_done),
        .ms_allowin     (ms_allowin),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_bus         (es_bus),
        .sram           (sram)
    );

    // divider only runs for the item held in this stage
    assert property (@(posedge clk) disable iff (reset) div_busy |-> item_valid);

endmodule

//--- verification/exe_checker.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_checker #(
    parameter int ROWS = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_valid,
    input  exe_pkg::ds_to_es_t ds_bus,
    input  logic               ms_allowin,
    input  logic               es_allowin,
    input  logic               es_to_ms_valid,
    input  exe_pkg::es_to_ms_t es_bus,
    input  exe_pkg::sram_req_t sram,
    input  exe_pkg::ds_to_es_t exp_bus [ROWS],
    input  logic [31:0]        exp_result [ROWS],
    input  logic [4:0]         exp_flags [ROWS],
    input  logic [3:0]         exp_wen [ROWS],
    input  logic [31:0]        exp_wdata [ROWS],
    input  logic [31:0]        exp_br [ROWS],
    input  logic [31:0]        exp_pc [ROWS],
    output int                 errors,
    output int                 delivered
);

    localparam int IDX_W = $clog2(ROWS);

    logic               held_div;
    logic               offered;
    int                 wait_cycles;
    exe_pkg::es_to_ms_t bus_snap;
    exe_pkg::sram_req_t sram_snap;

    task automatic compare_field(input string field, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("Fail %0t: row %0d %s is %h, expected %h", $time, delivered, field, got, want);
        end
    endtask

    task automatic check_row();
        logic [IDX_W-1:0] i;
        i = IDX_W'(delivered);
        compare_field("pc", es_bus.pc, exp_pc[i]);
        compare_field("result", es_bus.result, exp_result[i]);
        // flags only matter for rows that exercise the adder
        if (exp_flags[i][4]) begin
            compare_field("flags", 32'({es_bus.carry, es_bus.sign, es_bus.overflow, es_bus.zero}),
                          32'(exp_flags[i][3:0]));
        end
        compare_field("wen", 32'(sram.wen), 32'(exp_wen[i]));
        if (exp_wen[i] != 4'b0000) begin
            compare_field("addr", sram.addr, exp_result[i]);
            compare_field("wdata", sram.wdata, exp_wdata[i]);
        end
        compare_field("br_target", es_bus.br_target, exp_br[i]);
        // fields that pass straight through to memory
        compare_field("branch_op", 32'(es_bus.branch_op), 32'(exp_bus[i].branch_op));
        compare_field("load_op", 32'(es_bus.load_op), 32'(exp_bus[i].load_op));
        compare_field("mem_to_reg", 32'(es_bus.mem_to_reg), 32'(exp_bus[i].mem_to_reg));
        compare_field("reg_we", 32'(es_bus.reg_we), 32'(exp_bus[i].reg_we));
        compare_field("dest", 32'(es_bus.dest), 32'(exp_bus[i].dest));
        compare_field("en", 32'(sram.en), 32'd1);
    endtask

    // sampled mid-cycle away from both drive points
    always @(negedge clk) begin
        if (reset) begin
            held_div    = 1'b0;
            offered     = 1'b0;
            wait_cycles = 0;
            errors      = 0;
            delivered   = 0;
        end else begin
            if (es_to_ms_valid) begin
                if (!offered) begin
                    compare_field("latency", 32'(wait_cycles),
                                  32'(held_div ? `EXE_DIV_CYCLES : 0));
                end else if (es_bus !== bus_snap || sram !== sram_snap) begin
                    errors++;
                    $display("Fail %0t: row %0d outputs changed while stalled", $time, delivered);
                end
                if (ms_allowin) begin
                    if (delivered >= ROWS) begin
                        errors++;
                        $display("extra item delivered at %0t beyond the table", $time);
                    end else begin
                        check_row();
                    end
                    delivered++;
                    offered = 1'b0;
                end else begin
                    offered   = 1'b1;
                    bus_snap  = es_bus;
                    sram_snap = sram;
                end
            end else if (offered) begin
                errors++;
                $display("item withdrawn at %0t while memory stage stalled", $time);
                offered = 1'b0;
            end else begin
                wait_cycles++;
            end
            // new item enters on the next rising edge
            if (ds_valid && es_allowin) begin
                held_div    = |ds_bus.alu_op[`EXE_OP_MODWU:`EXE_OP_DIVW];
                wait_cycles = 0;
            end
        end
    end

endmodule

//--- verification/exe_stage_tb.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_stage_tb;

    localparam int ROWS  = 28;
    localparam int IDX_W = $clog2(ROWS);
    localparam int LIMIT = ROWS * (`EXE_DIV_CYCLES + 8) + 50;

    logic               clk;
    logic               reset;
    logic               ds_valid;
    exe_pkg::ds_to_es_t ds_bus;
    exe_pkg::fw_sel_t   fw_sel;
    logic [31:0]        ms_fwd;
    logic [31:0]        ws_fwd;
    logic               ms_allowin;
    logic               es_allowin;
    logic               es_to_ms_valid;
    exe_pkg::es_to_ms_t es_bus;
    exe_pkg::sram_req_t sram;

    exe_pkg::ds_to_es_t stim_bus [ROWS];
    exe_pkg::fw_sel_t   stim_fw [ROWS];
    logic [31:0]        exp_result [ROWS];
    logic [4:0]         exp_flags [ROWS];
    logic [3:0]         exp_wen [ROWS];
    logic [31:0]        exp_wdata [ROWS];
    logic [31:0]        exp_br [ROWS];
    logic [31:0]        exp_pc [ROWS];

    int          n_rows;
    int          row;
    int          errors;
    int          delivered;
    int          cycles = 0;
    logic        accepted;
    logic [31:0] lfsr;

    exe_stage exe_stage_i (
        .clk            (clk),
        .reset          (reset),
        .ds_valid       (ds_valid),
        .ds_bus         (ds_bus),
        .fw_sel         (fw_sel),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .ms_allowin     (ms_allowin),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_bus         (es_bus),
        .sram           (sram)
    );

    exe_checker #(.ROWS(ROWS)) checker_i (
        .clk            (clk),
        .reset          (reset),
        .ds_valid       (ds_valid),
        .ds_bus         (ds_bus),
        .ms_allowin     (ms_allowin),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_bus         (es_bus),
        .sram           (sram),
        .exp_bus        (stim_bus),
        .exp_result     (exp_result),
        .exp_flags      (exp_flags),
        .exp_wen        (exp_wen),
        .exp_wdata      (exp_wdata),
        .exp_br         (exp_br),
        .exp_pc         (exp_pc),
        .errors         (errors),
        .delivered      (delivered)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic draw_allowin();
        logic b0;
        logic b1;
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        // stall about one cycle in four
        ms_allowin = !(b0 && b1);
    endtask

    // ctl is {src1_is_pc, src2_is_imm, src2_is_4}
    // flg is {check, c, s, o, z}
    task automatic add_row(input int op, input logic [2:0] ctl, input logic [2:0] st,
                           input logic [8:0] br, input logic [31:0] imm, r1, r2,
                           input logic [4:0] fw, input logic [31:0] res,
                           input logic [4:0] flg, input logic [3:0] wen,
                           input logic [31:0] wdata, br_t);
        exe_pkg::ds_to_es_t b;
        logic [IDX_W-1:0]   i;
        i = IDX_W'(n_rows);
        b = '0;
        b.alu_op      = 16'(1) << op;
        b.src1_is_pc  = ctl[2];
        b.src2_is_imm = ctl[1];
        b.src2_is_4   = ctl[0];
        b.mem_we      = |st;
        b.reg_we      = ~|st;
        b.store_op    = st;
        // odd non-store rows also carry a load op
        if (~|st && n_rows[0]) begin
            b.mem_to_reg = 1'b1;
            b.load_op    = 5'(1) << (n_rows % 5);
        end
        b.branch_op   = br;
        b.dest        = 5'(n_rows);
        b.imm         = imm;
        b.rdata1      = r1;
        b.rdata2      = r2;
        b.pc          = 32'h1c00_0000 + 32'(n_rows * 4);
        stim_bus[i]   = b;
        stim_fw[i]    = fw;
        exp_result[i] = res;
        exp_flags[i]  = flg;
        exp_wen[i]    = wen;
        exp_wdata[i]  = wdata;
        exp_br[i]     = br_t;
        exp_pc[i]     = b.pc;
        n_rows++;
    endtask

    // forwarded values are fixed at ms 0x300 and ws 0x12345678
    task automatic load_table();
        add_row(`EXE_OP_ADD, 3'b000, 3'b000, 9'h000, 'h0, 'h7fffffff, 'h00000001, 5'b00000,
                'h80000000, 5'b10110, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_SUB, 3'b000, 3'b000, 9'h000, 'h0, 'h00001234, 'h00001234, 5'b00000,
                'h00000000, 5'b11001, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_SLT, 3'b000, 3'b000, 9'h000, 'h0, 'hfffffff0, 'h00000005, 5'b00000,
                'h00000001, 5'b11100, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_SLTU, 3'b000, 3'b000, 9'h000, 'h0, 'h00000005, 'hfffffff0, 5'b00000,
                'h00000001, 5'b10000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_NOR, 3'b000, 3'b000, 9'h000, 'h0, 'hf0f00000, 'h0f0000ff, 5'b00000,
                'h000fff00, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_OR, 3'b010, 3'b000, 9'h000, 'h00000abc, 'h12000000, 'hffffffff, 5'b00100,
                'h12000abc, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_SLL, 3'b000, 3'b000, 9'h000, 'h0, 'h00000003, 'h00000024, 5'b00000,
                'h00000030, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_SRA, 3'b000, 3'b000, 9'h000, 'h0, 'h80000000, 'h00000004, 5'b00000,
                'hf8000000, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_LUI, 3'b010, 3'b000, 9'h000, 'hfff12345, 'h0, 'h0, 5'b00000,
                'h12345000, 5'b00000, 4'b0000, 'h0, 'h0);
        // pc and 4 win over forwarding
        add_row(`EXE_OP_ADD, 3'b101, 3'b000, 9'h001, 'h00000100, 'h0, 'h0, 5'b10100,
                'h1c000028, 5'b10000, 4'b0000, 'h0, 'h1c000124);
        add_row(`EXE_OP_ADD, 3'b000, 3'b000, 9'h100, 'h00000010, 'h00008000, 'h0, 5'b11010,
                'h12345978, 5'b10000, 4'b0000, 'h0, 'h00008010);
        add_row(`EXE_OP_DIVW, 3'b000, 3'b000, 9'h000, 'h0, 'hfffffff9, 'h00000002, 5'b00000,
                'hfffffffd, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_MODW, 3'b000, 3'b000, 9'h000, 'h0, 'hfffffff9, 'h00000002, 5'b00000,
                'hffffffff, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_DIVW, 3'b000, 3'b000, 9'h000, 'h0, 'h80000000, 'hffffffff, 5'b00000,
                'h80000000, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_DIVWU, 3'b000, 3'b000, 9'h000, 'h0, 'hfffffff9, 'h00000002, 5'b00000,
                'h7ffffffc, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_MODWU, 3'b000, 3'b000, 9'h000, 'h0, 'h0, 'h00000100, 5'b01000,
                'h00000078, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_DIVW, 3'b000, 3'b000, 9'h000, 'h0, 'h00000064, 'h0, 5'b00000,
                'hffffffff, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_MODW, 3'b000, 3'b000, 9'h000, 'h0, 'hfffffff9, 'h0, 5'b00000,
                'hfffffff9, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_ADD, 3'b010, 3'b001, 9'h000, 'h0, 'h00001000, 'haabbccdd, 5'b00000,
                'h00001000, 5'b00000, 4'b0001, 'hdddddddd, 'h0);
        add_row(`EXE_OP_ADD, 3'b010, 3'b001, 9'h000, 'h1, 'h00001000, 'haabbccdd, 5'b00000,
                'h00001001, 5'b00000, 4'b0010, 'hdddddddd, 'h0);
        add_row(`EXE_OP_ADD, 3'b010, 3'b001, 9'h000, 'h2, 'h00001000, 'haabbccdd, 5'b00001,
                'h00001002, 5'b00000, 4'b0100, 'h78787878, 'h0);
        add_row(`EXE_OP_ADD, 3'b010, 3'b001, 9'h000, 'h3, 'h00001000, 'haabbccdd, 5'b00000,
                'h00001003, 5'b00000, 4'b1000, 'hdddddddd, 'h0);
        add_row(`EXE_OP_ADD, 3'b010, 3'b010, 9'h000, 'h0, 'h00001000, 'haabbccdd, 5'b00000,
                'h00001000, 5'b00000, 4'b0011, 'hccddccdd, 'h0);
        add_row(`EXE_OP_ADD, 3'b010, 3'b010, 9'h000, 'h2, 'h00001000, 'haabbccdd, 5'b00001,
                'h00001002, 5'b00000, 4'b1100, 'h56785678, 'h0);
        add_row(`EXE_OP_ADD, 3'b010, 3'b100, 9'h000, 'h4, 'h00001000, 'haabbccdd, 5'b00001,
                'h00001004, 5'b00000, 4'b1111, 'h12345678, 'h0);
        // src2 from ms wins over ws
        add_row(`EXE_OP_AND, 3'b000, 3'b000, 9'h000, 'h0, 'hffff0f0f, 'hdeadbeef, 5'b00110,
                'h00000300, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_XOR, 3'b000, 3'b000, 9'h000, 'h0, 'hff00ff00, 'h0ff00ff0, 5'b00000,
                'hf0f0f0f0, 5'b00000, 4'b0000, 'h0, 'h0);
        add_row(`EXE_OP_SRL, 3'b000, 3'b000, 9'h000, 'h0, 'h80000000, 'h0000003f, 5'b00000,
                'h00000001, 5'b00000, 4'b0000, 'h0, 'h0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, simulation stopped", cycles);
            $display("errors: %0d, rows delivered: %0d of %0d", errors, delivered, ROWS);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        ds_valid   = 1'b0;
        ds_bus     = '0;
        fw_sel     = '0;
        ms_fwd     = 32'h0000_0300;
        ws_fwd     = 32'h1234_5678;
        ms_allowin = 1'b0;
        lfsr       = 32'h30b0;
        n_rows     = 0;
        load_table();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        row   = 0;
        while (row < ROWS) begin
            ds_valid = 1'b1;
            ds_bus   = stim_bus[IDX_W'(row)];
            draw_allowin();
            @(negedge clk);
            accepted = es_allowin;
            @(posedge clk);
            #1;
            // forwarding follows the item now held in the stage
            if (accepted) begin
                fw_sel = stim_fw[IDX_W'(row)];
                row++;
            end
        end
        ds_valid = 1'b0;
        while (delivered < ROWS) begin
            @(posedge clk);
            #1;
            draw_allowin();
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d, rows delivered: %0d of %0d", errors, delivered, ROWS);
        if (errors == 0 && delivered == ROWS) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+rtl
rtl/exe_pkg.sv
rtl/exe_issue.sv
rtl/exe_alu.sv
rtl/exe_divider.sv
rtl/exe_retire.sv
rtl/exe_stage.sv
verification/exe_checker.sv
verification/exe_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
    --top-module exe_stage_tb -o exe_stage_sim &&
./obj_dir/exe_stage_sim | tee /dev/stderr | grep -q -x "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
